//--- filelist.f
rtl/axi_lite_pkg.sv
rtl/axi_lite_if.sv
rtl/spill_register.sv
rtl/axi_lite_cut.sv
rtl/axi_lite_mem.sv
rtl/axi_lite_cut_top.sv
testbench/tb_axi_lite_cut_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_axi_lite_cut_top
FILELIST  ?= filelist.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/tb_axi_lite_cut_top.sv
`timescale 1ns/10ps
// Testbench for the AXI4-Lite cut top level, random traffic checked against a memory model
module tb_axi_lite_cut_top;
  import axi_lite_pkg::*;

  logic              clk_i = 1'b0;
  logic              rst_n_i = 1'b0;
  logic              aw_valid_i = 1'b0;
  logic              w_valid_i = 1'b0;
  logic              ar_valid_i = 1'b0;
  logic              b_ready_i = 1'b0;
  logic              r_ready_i = 1'b0;
  logic [ADDR_W-1:0] aw_addr_i = '0;
  logic [ADDR_W-1:0] ar_addr_i = '0;
  logic [DATA_W-1:0] w_data_i = '0;
  logic [STRB_W-1:0] w_strb_i = '0;
  logic              aw_ready_o, w_ready_o, ar_ready_o, b_valid_o, r_valid_o;
  logic [DATA_W-1:0] r_data_o;
  logic [RESP_W-1:0] b_resp_o, r_resp_o;

  // Stimulus plans, model memory and expected responses
  integer            seed = 32'hae76;
  logic [ADDR_W-1:0] aw_plan_q[$], ar_plan_q[$], aw_seen_q[$], rd_list[$];
  logic [W_W-1:0]    w_plan_q[$], w_seen_q[$];
  logic [B_W-1:0]    exp_b_q[$];
  logic [R_W-1:0]    exp_r_q[$];
  logic [DATA_W-1:0] model_mem [MEM_DEPTH];
  logic [B_W-1:0]    b_prev;
  logic [R_W-1:0]    r_prev;
  int unsigned       valid_pct, b_stall, r_stall;
  bit                stall_en, drive_en, idle_q, b_hold, r_hold;
  bit                aw_fire, w_fire, ar_fire, b_fire, r_fire;
  int                err_cnt, check_cnt, timeout_cnt, wr_sent, rd_sent, b_got, r_got;

  axi_lite_cut_top u_dut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_addr_i  (aw_addr_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_resp_o   (b_resp_o),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_addr_i  (ar_addr_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic bit roll(input int unsigned pct);
    return (rnd() % 100) < pct;
  endfunction

  function automatic int unsigned word_of(input logic [ADDR_W-1:0] a);
    return 32'(a) >> 2;
  endfunction

  function automatic bit in_range(input logic [ADDR_W-1:0] a);
    return word_of(a) < MEM_DEPTH;
  endfunction

  // One in five addresses lands past the end of the memory
  function automatic logic [ADDR_W-1:0] pick_addr(input int unsigned base);
    int unsigned word;
    if (roll(20)) begin
      word = MEM_DEPTH + rnd() % ((1 << (ADDR_W - 2)) - MEM_DEPTH);
    end else begin
      word = base + rnd() % (MEM_DEPTH / 2);
    end
    return ADDR_W'(word << 2);
  endfunction

  // Payload layout is {data, strb}
  function automatic void model_write(input logic [ADDR_W-1:0] a, input logic [W_W-1:0] wd);
    int b;
    if (in_range(a)) begin
      for (b = 0; b < STRB_W; b++) begin
        if (wd[b]) begin
          model_mem[word_of(a)][8*b +: 8] = wd[STRB_W + 8*b +: 8];
        end
      end
    end
    exp_b_q.push_back(in_range(a) ? RESP_OKAY : RESP_SLVERR);
    wr_sent++;
  endfunction

  function automatic logic [R_W-1:0] model_read(input logic [ADDR_W-1:0] a);
    rd_sent++;
    if (in_range(a)) begin
      return {model_mem[word_of(a)], RESP_OKAY};
    end
    return {{DATA_W{1'b0}}, RESP_SLVERR};
  endfunction

  task automatic take_b();
    if (exp_b_q.size() == 0) begin
      err_cnt++;
      $display("Unexpected write response at %0t with no write outstanding", $time);
    end else begin
      check_cnt++;
      if (b_resp_o !== exp_b_q[0]) begin
        err_cnt++;
        $display("CHECK FAILED at %0t: write response %0d, expected %0d",
                 $time, b_resp_o, exp_b_q[0]);
      end
      void'(exp_b_q.pop_front());
    end
    b_got++;
  endtask

  task automatic take_r();
    logic [R_W-1:0] exp;
    if (exp_r_q.size() == 0) begin
      err_cnt++;
      $display("Unexpected read response at %0t with no read outstanding", $time);
    end else begin
      exp = exp_r_q.pop_front();
      check_cnt++;
      if ({r_data_o, r_resp_o} !== exp) begin
        err_cnt++;
        $display("CHECK FAILED at %0t: read data %h resp %0d, expected %h resp %0d",
                 $time, r_data_o, r_resp_o, exp[R_W-1:RESP_W], exp[RESP_W-1:0]);
      end
    end
    r_got++;
  endtask

  // Drive the top level; a valid only drops or moves on after its transfer
  always @(posedge clk_i) begin
    if (drive_en) begin
      if (!aw_valid_i || aw_fire) begin
        aw_valid_i <= 1'b0;
        if (aw_plan_q.size() > 0 && roll(valid_pct)) begin
          aw_valid_i <= 1'b1;
          aw_addr_i  <= aw_plan_q.pop_front();
        end
      end
      if (!w_valid_i || w_fire) begin
        w_valid_i <= 1'b0;
        if (w_plan_q.size() > 0 && roll(valid_pct)) begin
          w_valid_i            <= 1'b1;
          {w_data_i, w_strb_i} <= w_plan_q.pop_front();
        end
      end
      if (!ar_valid_i || ar_fire) begin
        ar_valid_i <= 1'b0;
        if (ar_plan_q.size() > 0 && roll(valid_pct)) begin
          ar_valid_i <= 1'b1;
          ar_addr_i  <= ar_plan_q.pop_front();
        end
      end
      // Response back-pressure in random stretches
      if (stall_en && b_stall > 0) begin
        b_ready_i <= 1'b0;
        b_stall = b_stall - 1;
      end else if (stall_en && roll(15)) begin
        b_ready_i <= 1'b0;
        b_stall = rnd() % 8;
      end else begin
        b_ready_i <= 1'b1;
      end
      if (stall_en && r_stall > 0) begin
        r_ready_i <= 1'b0;
        r_stall = r_stall - 1;
      end else if (stall_en && roll(15)) begin
        r_ready_i <= 1'b0;
        r_stall = rnd() % 8;
      end else begin
        r_ready_i <= 1'b1;
      end
    end
  end

  // Sample mid-cycle, where inputs and outputs are settled for the next edge
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      aw_fire = aw_valid_i && aw_ready_o;
      w_fire  = w_valid_i && w_ready_o;
      ar_fire = ar_valid_i && ar_ready_o;
      b_fire  = b_valid_o && b_ready_i;
      r_fire  = r_valid_o && r_ready_i;
      if (aw_fire) begin
        aw_seen_q.push_back(aw_addr_i);
      end
      if (w_fire) begin
        w_seen_q.push_back({w_data_i, w_strb_i});
      end
      // The memory pairs AW and W in arrival order
      if (aw_seen_q.size() > 0 && w_seen_q.size() > 0) begin
        model_write(aw_seen_q.pop_front(), w_seen_q.pop_front());
      end
      if (ar_fire) begin
        exp_r_q.push_back(model_read(ar_addr_i));
      end
      if (b_hold && (!b_valid_o || b_resp_o !== b_prev)) begin
        err_cnt++;
        $display("CHECK FAILED at %0t: write response dropped or changed while stalled", $time);
      end
      if (r_hold && (!r_valid_o || {r_data_o, r_resp_o} !== r_prev)) begin
        err_cnt++;
        $display("CHECK FAILED at %0t: read response dropped or changed while stalled", $time);
      end
      if (b_fire) begin
        take_b();
      end
      if (r_fire) begin
        take_r();
      end
      b_hold = b_valid_o && !b_ready_i;
      r_hold = r_valid_o && !r_ready_i;
      b_prev = b_resp_o;
      r_prev = {r_data_o, r_resp_o};
      idle_q = aw_plan_q.size() == 0 && w_plan_q.size() == 0 && ar_plan_q.size() == 0 &&
               !aw_valid_i && !w_valid_i && !ar_valid_i && aw_seen_q.size() == 0 &&
               w_seen_q.size() == 0 && exp_b_q.size() == 0 && exp_r_q.size() == 0;
    end
  end

  // Phase 0 writes low words, 1 reads them back, 2 runs both at full rate on disjoint words
  task automatic load_phase(input int ph);
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    logic [STRB_W-1:0] s;
    int                i;
    @(negedge clk_i);
    stall_en  = (ph != 2);
    valid_pct = (ph == 2) ? 100 : 60;
    for (i = 0; i < 40; i++) begin
      d = rnd();
      s = STRB_W'(rnd());
      if (ph == 0) begin
        a = pick_addr(0);
        rd_list.push_back(a);
        aw_plan_q.push_back(a);
        w_plan_q.push_back({d, s});
      end else if (ph == 1) begin
        ar_plan_q.push_back(rd_list[i]);
      end else begin
        aw_plan_q.push_back(pick_addr(MEM_DEPTH / 2));
        w_plan_q.push_back({d, s});
        ar_plan_q.push_back(pick_addr(0));
      end
    end
  endtask

  task automatic wait_done(input int limit, output bit ok);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    @(posedge clk_i);
    while (!idle_q && cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    ok = idle_q;
    if (!ok) begin
      timeout_cnt++;
      $display("Timeout after %0d cycles with requests or responses still outstanding", limit);
    end
  endtask

  initial begin
    int ph;
    int i;
    bit ok;
    for (i = 0; i < MEM_DEPTH; i++) begin
      model_mem[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_cnt++;
    if (b_valid_o || r_valid_o || !aw_ready_o || !w_ready_o || !ar_ready_o) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: handshake outputs not idle after reset", $time);
    end
    drive_en = 1'b1;
    ok = 1'b1;
    for (ph = 0; ph < 3 && ok; ph++) begin
      load_phase(ph);
      wait_done(4000, ok);
    end
    check_cnt++;
    if (b_got != wr_sent || r_got != rd_sent) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %0d writes got %0d responses, %0d reads got %0d",
               $time, wr_sent, b_got, rd_sent, r_got);
    end
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- rtl/axi_lite_cut_top.sv
`timescale 1ns/10ps
// Top level exposing AXI4-Lite subordinate ports, feeding a register cut and the memory
module axi_lite_cut_top (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Write address
  input  logic                              aw_valid_i,
  output logic                              aw_ready_o,
  input  logic [axi_lite_pkg::ADDR_W-1:0]   aw_addr_i,
  // Write data
  input  logic                              w_valid_i,
  output logic                              w_ready_o,
  input  logic [axi_lite_pkg::DATA_W-1:0]   w_data_i,
  input  logic [axi_lite_pkg::STRB_W-1:0]   w_strb_i,
  // Write response
  output logic                              b_valid_o,
  input  logic                              b_ready_i,
  output logic [axi_lite_pkg::RESP_W-1:0]   b_resp_o,
  // Read address
  input  logic                              ar_valid_i,
  output logic                              ar_ready_o,
  input  logic [axi_lite_pkg::ADDR_W-1:0]   ar_addr_i,
  // Read data
  output logic                              r_valid_o,
  input  logic                              r_ready_i,
  output logic [axi_lite_pkg::DATA_W-1:0]   r_data_o,
  output logic [axi_lite_pkg::RESP_W-1:0]   r_resp_o
);

  axi_lite_if outer ();
  axi_lite_if inner ();

  // Outside manager drives the outer bundle
  assign outer.aw_valid = aw_valid_i;
  assign outer.aw_addr  = aw_addr_i;
  assign outer.w_valid  = w_valid_i;
  assign outer.w_data   = w_data_i;
  assign outer.w_strb   = w_strb_i;
  assign outer.b_ready  = b_ready_i;
  assign outer.ar_valid = ar_valid_i;
  assign outer.ar_addr  = ar_addr_i;
  assign outer.r_ready  = r_ready_i;

  assign aw_ready_o = outer.aw_ready;
  assign w_ready_o  = outer.w_ready;
  assign b_valid_o  = outer.b_valid;
  assign b_resp_o   = outer.b_resp;
  assign ar_ready_o = outer.ar_ready;
  assign r_valid_o  = outer.r_valid;
  assign r_data_o   = outer.r_data;
  assign r_resp_o   = outer.r_resp;

  axi_lite_cut #(.Bypass(1'b0)) u_cut (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .sbr_port (outer.sbr),
    .mgr_port (inner.mgr)
  );

  axi_lite_mem u_mem (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .slv     (inner.sbr)
  );

endmodule

//--- rtl/axi_lite_mem.sv
`timescale 1ns/10ps
// AXI4-Lite subordinate over a byte-strobed word memory, SLVERR for addresses past its end
module axi_lite_mem (
  input logic     clk_i,
  input logic     rst_n_i,
  axi_lite_if.sbr slv
);
  import axi_lite_pkg::*;

  logic [DATA_W-1:0] mem_q [MEM_DEPTH];

  logic [ADDR_W-3:0] wr_word;
  logic [ADDR_W-3:0] rd_word;
  logic              wr_in_range;
  logic              rd_in_range;
  logic              wr_free;
  logic              rd_free;
  logic              wr_take;
  logic              rd_take;

  logic              b_valid_q;
  logic [RESP_W-1:0] b_resp_q;
  logic              r_valid_q;
  logic [RESP_W-1:0] r_resp_q;
  logic [DATA_W-1:0] r_data_q;

  // Word index drops the byte offset
  assign wr_word     = slv.aw_addr[ADDR_W-1:2];
  assign rd_word     = slv.ar_addr[ADDR_W-1:2];
  assign wr_in_range = wr_word < (ADDR_W-2)'(MEM_DEPTH);
  assign rd_in_range = rd_word < (ADDR_W-2)'(MEM_DEPTH);

  // Response slot is free when empty or draining this cycle
  assign wr_free = !b_valid_q || slv.b_ready;
  assign rd_free = !r_valid_q || slv.r_ready;

  // AW and W are only taken as a pair
  assign wr_take     = slv.aw_valid && slv.w_valid && wr_free;
  assign slv.aw_ready = wr_take;
  assign slv.w_ready  = wr_take;

  assign rd_take      = slv.ar_valid && rd_free;
  assign slv.ar_ready = rd_free;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_free) begin
        b_valid_q <= wr_take;
      end
      if (rd_free) begin
        r_valid_q <= rd_take;
      end
    end
  end

  // Response payloads
  always_ff @(posedge clk_i) begin
    if (wr_take) begin
      b_resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_take) begin
      r_resp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
      r_data_q <= rd_in_range ? mem_q[rd_word[MEM_IDX_W-1:0]] : '0;
    end
  end

  // Byte-wise write, nothing stored out of range
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_take && wr_in_range) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (slv.w_strb[b]) begin
          mem_q[wr_word[MEM_IDX_W-1:0]][8*b +: 8] <= slv.w_data[8*b +: 8];
        end
      end
    end
  end

  assign slv.b_valid = b_valid_q;
  assign slv.b_resp  = b_resp_q;
  assign slv.r_valid = r_valid_q;
  assign slv.r_resp  = r_resp_q;
  assign slv.r_data  = r_data_q;

  // Responses wait for the cut to accept them
  a_b_hold : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    slv.b_valid && !slv.b_ready |=> slv.b_valid
  ) else $error("axi_lite_mem dropped b_valid before b_ready");

  a_r_hold : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    slv.r_valid && !slv.r_ready |=> slv.r_valid
  ) else $error("axi_lite_mem dropped r_valid before r_ready");

endmodule

//--- rtl/axi_lite_cut.sv
`timescale 1ns/10ps
// AXI4-Lite cut with a spill register on each of the five channels
module axi_lite_cut #(
  parameter bit Bypass = 1'b0
) (
  input logic     clk_i,
  input logic     rst_n_i,
  axi_lite_if.sbr sbr_port,
  axi_lite_if.mgr mgr_port
);
  import axi_lite_pkg::*;

  // W and R carry more than one field
  logic [W_W-1:0] w_in;
  logic [W_W-1:0] w_out;
  logic [R_W-1:0] r_in;
  logic [R_W-1:0] r_out;

  assign w_in = {sbr_port.w_data, sbr_port.w_strb};
  assign {mgr_port.w_data, mgr_port.w_strb} = w_out;
  assign r_in = {mgr_port.r_data, mgr_port.r_resp};
  assign {sbr_port.r_data, sbr_port.r_resp} = r_out;

  // Requests, subordinate side to manager side
  spill_register #(.Width(AW_W), .Bypass(Bypass)) i_reg_aw (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (sbr_port.aw_valid),
    .ready_o (sbr_port.aw_ready),
    .data_i  (sbr_port.aw_addr),
    .valid_o (mgr_port.aw_valid),
    .ready_i (mgr_port.aw_ready),
    .data_o  (mgr_port.aw_addr)
  );

  spill_register #(.Width(W_W), .Bypass(Bypass)) i_reg_w (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (sbr_port.w_valid),
    .ready_o (sbr_port.w_ready),
    .data_i  (w_in),
    .valid_o (mgr_port.w_valid),
    .ready_i (mgr_port.w_ready),
    .data_o  (w_out)
  );

  spill_register #(.Width(AR_W), .Bypass(Bypass)) i_reg_ar (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (sbr_port.ar_valid),
    .ready_o (sbr_port.ar_ready),
    .data_i  (sbr_port.ar_addr),
    .valid_o (mgr_port.ar_valid),
    .ready_i (mgr_port.ar_ready),
    .data_o  (mgr_port.ar_addr)
  );

  // Responses travel back
  spill_register #(.Width(B_W), .Bypass(Bypass)) i_reg_b (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (mgr_port.b_valid),
    .ready_o (mgr_port.b_ready),
    .data_i  (mgr_port.b_resp),
    .valid_o (sbr_port.b_valid),
    .ready_i (sbr_port.b_ready),
    .data_o  (sbr_port.b_resp)
  );

  spill_register #(.Width(R_W), .Bypass(Bypass)) i_reg_r (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (mgr_port.r_valid),
    .ready_o (mgr_port.r_ready),
    .data_i  (r_in),
    .valid_o (sbr_port.r_valid),
    .ready_i (sbr_port.r_ready),
    .data_o  (r_out)
  );

endmodule

//--- rtl/spill_register.sv
`timescale 1ns/10ps
// Two-slot valid/ready stage that registers valid, ready and data, or a plain wire in bypass
module spill_register #(
  parameter int unsigned Width  = 32,
  parameter bit          Bypass = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  if (Bypass) begin : g_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : g_spill
    logic             prim_full_q;
    logic             spill_full_q;
    logic [Width-1:0] prim_data_q;
    logic [Width-1:0] spill_data_q;
    logic             in_fire;
    logic             out_fire;
    logic             prim_load;
    logic             spill_load;

    assign in_fire  = valid_i && ready_o;
    assign out_fire = prim_full_q && ready_i;

    // Primary reloads whenever it is empty or handing its item over
    assign prim_load = !prim_full_q || out_fire;

    // Input only parks in the spill slot while the primary is stuck
    assign spill_load = in_fire && !prim_load;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        prim_full_q  <= 1'b0;
        spill_full_q <= 1'b0;
      end else begin
        if (prim_load) begin
          prim_full_q <= spill_full_q || in_fire;
        end
        // A full spill slot always moves up when the primary reloads
        if (prim_load) begin
          spill_full_q <= 1'b0;
        end else if (spill_load) begin
          spill_full_q <= 1'b1;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (prim_load && (spill_full_q || in_fire)) begin
        prim_data_q <= spill_full_q ? spill_data_q : data_i;
      end
      if (spill_load) begin
        spill_data_q <= data_i;
      end
    end

    // Ready is pure state, so the input side sees no path from ready_i
    assign ready_o = !spill_full_q;
    assign valid_o = prim_full_q;
    assign data_o  = prim_data_q;

    // Stalled output keeps both its valid and its payload
    a_hold_stalled : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      valid_o && !ready_i |=> valid_o && $stable(data_o)
    ) else $error("spill_register output changed while stalled");
  end

endmodule

//--- rtl/axi_lite_if.sv
`timescale 1ns/10ps
// AXI4-Lite signal bundle between the cut and the memory, with manager and subordinate views
interface axi_lite_if ();
  import axi_lite_pkg::*;

  // Write address
  logic              aw_valid;
  logic              aw_ready;
  logic [ADDR_W-1:0] aw_addr;

  // Write data
  logic              w_valid;
  logic              w_ready;
  logic [DATA_W-1:0] w_data;
  logic [STRB_W-1:0] w_strb;

  // Write response
  logic              b_valid;
  logic              b_ready;
  logic [RESP_W-1:0] b_resp;

  // Read address
  logic              ar_valid;
  logic              ar_ready;
  logic [ADDR_W-1:0] ar_addr;

  // Read data
  logic              r_valid;
  logic              r_ready;
  logic [DATA_W-1:0] r_data;
  logic [RESP_W-1:0] r_resp;

  // Side that issues requests
  modport mgr (
    output aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready, ar_valid, ar_addr, r_ready,
    input  aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
  );

  // Side that answers them
  modport sbr (
    input  aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready, ar_valid, ar_addr, r_ready,
    output aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
  );

endinterface

//--- rtl/axi_lite_pkg.sv
// Shared widths, memory size and response codes for the AXI4-Lite cut and its memory
package axi_lite_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned RESP_W = 2;

  // Response codes
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;

  // Word memory behind the cut, indexed by byte address / 4
  localparam int unsigned MEM_DEPTH = 256;
  localparam int unsigned MEM_IDX_W = $clog2(MEM_DEPTH);

  // Concatenated payload per channel
  localparam int unsigned AW_W = ADDR_W;
  localparam int unsigned W_W  = DATA_W + STRB_W;
  localparam int unsigned B_W  = RESP_W;
  localparam int unsigned AR_W = ADDR_W;
  localparam int unsigned R_W  = DATA_W + RESP_W;

endpackage
